/* common/ether_pkg.sv */
`default_nettype none

package ether_pkg;

   // symbol on the shared line
   // jam encodes as the all-zero code
   typedef enum logic [1:0] {
      SYM_JAM  = 2'd0,
      SYM_DATA = 2'd1,
      SYM_IDLE = 2'd2
   } sym_t;

   // result of one send request
   typedef enum logic [1:0] {
      TX_FAIL = 2'd0,
      TX_OK   = 2'd1,
      TX_NONE = 2'd2
   } tx_status_t;

   // transmitter FSM
   typedef enum logic [2:0] {
      TX_IDLE    = 3'd0,
      TX_DEFER   = 3'd1,
      TX_SEND    = 3'd2,
      TX_JAM     = 3'd3,
      TX_BACKOFF = 3'd4,
      TX_SETTLE  = 3'd5
   } tx_state_t;

   // bus size
   localparam int N_STATIONS    = 4;
   localparam int STATION_W     = 2;

   // frame shape in line symbols
   localparam int FRAME_SYMBOLS = 4;
   localparam int JAM_SYMBOLS   = 2;
   // wide enough for a data run one past a full frame
   localparam int SYM_CNT_W     = 3;

   // retry policy
   localparam int MAX_ATTEMPTS  = 3;
   localparam int ATTEMPT_W     = 2;
   localparam int BACKOFF_SLOT  = 8;
   // quiet cycles after the last data symbol
   // long enough for the channel round trip
   localparam int SETTLE_CYCLES = 3;
   localparam int DELAY_W       = 7;

endpackage

`default_nettype wire

/* design/request_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module request_dispatch (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic [ether_pkg::N_STATIONS-1:0] tx_req,
   input  logic [ether_pkg::N_STATIONS-1:0] tx_done,
   output logic [ether_pkg::N_STATIONS-1:0] tx_pending
);

   // one pending flag per station
   // held until the transmitter reports a result
   // a request to a busy station leaves the flag as it is
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         tx_pending <= '0;
      end
      else
      begin
         for (int i = 0; i < ether_pkg::N_STATIONS; i++)
         begin
            // done wins over a request in the same cycle
            if (tx_done[i])
            begin
               tx_pending[i] <= 1'b0;
            end
            // set one cycle after the strobe
            else if (tx_req[i])
            begin
               tx_pending[i] <= 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

/* station/frame_transmitter.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_transmitter #(
   parameter int STATION_ID = 0
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  tx_pending,
   input  logic                  carrier_sense,
   input  logic                  collision,
   output ether_pkg::sym_t       tx_sym,
   output logic                  tx_done,
   output ether_pkg::tx_status_t tx_status
);

   ether_pkg::tx_state_t state;

   // shared by data, settle and jam phases
   logic [ether_pkg::SYM_CNT_W-1:0] step_cnt;
   // collisions seen in this request
   logic [ether_pkg::ATTEMPT_W-1:0] attempt_cnt;
   // backoff countdown
   logic [ether_pkg::DELAY_W-1:0]   delay_cnt;

   // station index plus one, scales the backoff
   logic [ether_pkg::STATION_W:0]   slot_mult;
   logic [ether_pkg::DELAY_W-1:0]   backoff_len;
   logic                            last_attempt;
   logic                            hit;

   assign slot_mult = (ether_pkg::STATION_W + 1)'(STATION_ID + 1);

   // (i+1) * k * slot, k already counts the current collision
   assign backoff_len = (ether_pkg::DELAY_W)'(slot_mult * attempt_cnt * ether_pkg::BACKOFF_SLOT);

   assign last_attempt = attempt_cnt == (ether_pkg::ATTEMPT_W)'(ether_pkg::MAX_ATTEMPTS);

   // collision only counts while our frame may be on the line
   assign hit = collision && (state == ether_pkg::TX_SEND || state == ether_pkg::TX_SETTLE);

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state       <= ether_pkg::TX_IDLE;
         tx_sym      <= ether_pkg::SYM_IDLE;
         tx_done     <= 1'b0;
         tx_status   <= ether_pkg::TX_NONE;
         step_cnt    <= '0;
         attempt_cnt <= '0;
         delay_cnt   <= '0;
      end
      else
      begin
         // result strobe lasts one cycle
         tx_done   <= 1'b0;
         tx_status <= ether_pkg::TX_NONE;

         if (hit)
         begin
            // abort frame, first jam symbol
            tx_sym      <= ether_pkg::SYM_JAM;
            step_cnt    <= (ether_pkg::SYM_CNT_W)'(1);
            attempt_cnt <= attempt_cnt + 1'b1;
            state       <= ether_pkg::TX_JAM;
         end
         else
         begin
            case (state)
               ether_pkg::TX_IDLE:
               begin
                  // pending still high during our own done cycle
                  if (tx_pending && !tx_done)
                  begin
                     attempt_cnt <= '0;
                     state       <= ether_pkg::TX_DEFER;
                  end
               end
               ether_pkg::TX_DEFER:
               begin
                  // wait out any carrier
                  if (!carrier_sense)
                  begin
                     tx_sym   <= ether_pkg::SYM_DATA;
                     step_cnt <= (ether_pkg::SYM_CNT_W)'(1);
                     state    <= ether_pkg::TX_SEND;
                  end
               end
               ether_pkg::TX_SEND:
               begin
                  if (step_cnt == (ether_pkg::SYM_CNT_W)'(ether_pkg::FRAME_SYMBOLS))
                  begin
                     // frame out, idle marks its end
                     tx_sym   <= ether_pkg::SYM_IDLE;
                     step_cnt <= '0;
                     state    <= ether_pkg::TX_SETTLE;
                  end
                  else
                  begin
                     step_cnt <= step_cnt + 1'b1;
                  end
               end
               ether_pkg::TX_SETTLE:
               begin
                  // late collisions still arrive here
                  if (step_cnt == (ether_pkg::SYM_CNT_W)'(ether_pkg::SETTLE_CYCLES - 1))
                  begin
                     tx_done   <= 1'b1;
                     tx_status <= ether_pkg::TX_OK;
                     state     <= ether_pkg::TX_IDLE;
                  end
                  else
                  begin
                     step_cnt <= step_cnt + 1'b1;
                  end
               end
               ether_pkg::TX_JAM:
               begin
                  if (step_cnt == (ether_pkg::SYM_CNT_W)'(ether_pkg::JAM_SYMBOLS))
                  begin
                     tx_sym <= ether_pkg::SYM_IDLE;
                     if (last_attempt)
                     begin
                        // out of attempts
                        tx_done   <= 1'b1;
                        tx_status <= ether_pkg::TX_FAIL;
                        state     <= ether_pkg::TX_IDLE;
                     end
                     else
                     begin
                        delay_cnt <= backoff_len - (ether_pkg::DELAY_W)'(1);
                        state     <= ether_pkg::TX_BACKOFF;
                     end
                  end
                  else
                  begin
                     step_cnt <= step_cnt + 1'b1;
                  end
               end
               ether_pkg::TX_BACKOFF:
               begin
                  // then retry through deferral
                  if (delay_cnt == '0)
                  begin
                     state <= ether_pkg::TX_DEFER;
                  end
                  else
                  begin
                     delay_cnt <= delay_cnt - 1'b1;
                  end
               end
               default:
               begin
                  state <= ether_pkg::TX_IDLE;
               end
            endcase
         end
      end
   end

endmodule

`default_nettype wire

/* station/frame_receiver.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_receiver (
   input  logic            clk,
   input  logic            rst_n,
   input  ether_pkg::sym_t line_sym,
   output logic            rx_frame
);

   // consecutive data symbols seen on the line
   logic [ether_pkg::SYM_CNT_W-1:0] run_cnt;
   // exactly one frame worth of data
   logic                            run_full;
   // run too long, sticks until idle or jam
   logic                            run_over;

   assign run_full = run_cnt == (ether_pkg::SYM_CNT_W)'(ether_pkg::FRAME_SYMBOLS);
   assign run_over = run_cnt == (ether_pkg::SYM_CNT_W)'(ether_pkg::FRAME_SYMBOLS + 1);

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         run_cnt  <= '0;
         rx_frame <= 1'b0;
      end
      else
      begin
         rx_frame <= 1'b0;
         case (line_sym)
            ether_pkg::SYM_DATA:
            begin
               // saturate one past a full frame
               if (!run_over)
               begin
                  run_cnt <= run_cnt + 1'b1;
               end
            end
            ether_pkg::SYM_IDLE:
            begin
               // end of run, good only at full length
               rx_frame <= run_full;
               run_cnt  <= '0;
            end
            default:
            begin
               // jam breaks any partial frame
               run_cnt <= '0;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* station/station.sv */
`timescale 1ns/1ps
`default_nettype none

module station #(
   parameter int STATION_ID = 0
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  tx_pending,
   input  logic                  carrier_sense,
   input  logic                  collision,
   input  ether_pkg::sym_t       line_sym,
   output ether_pkg::sym_t       tx_sym,
   output logic                  tx_done,
   output ether_pkg::tx_status_t tx_status,
   output logic                  rx_frame
);

   // send side, index sets the backoff length
   frame_transmitter #(
      .STATION_ID (STATION_ID)
   ) transmitter_inst (
      .clk           (clk),
      .rst_n         (rst_n),
      .tx_pending    (tx_pending),
      .carrier_sense (carrier_sense),
      .collision     (collision),
      .tx_sym        (tx_sym),
      .tx_done       (tx_done),
      .tx_status     (tx_status)
   );

   // receive side listens to the merged line
   // own frames included
   frame_receiver receiver_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .line_sym (line_sym),
      .rx_frame (rx_frame)
   );

endmodule

`default_nettype wire

/* design/bus_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_channel (
   input  logic            clk,
   input  logic            rst_n,
   input  ether_pkg::sym_t tx_sym [ether_pkg::N_STATIONS],
   input  logic            line_noise,
   output ether_pkg::sym_t line_sym,
   output logic            carrier_sense,
   output logic            collision
);

   // stations not idle this cycle
   logic [ether_pkg::STATION_W:0] sender_cnt;
   logic                          any_jam;
   logic                          collide;
   ether_pkg::sym_t               merged_sym;

   always_comb
   begin
      sender_cnt = '0;
      any_jam    = 1'b0;
      for (int i = 0; i < ether_pkg::N_STATIONS; i++)
      begin
         if (tx_sym[i] != ether_pkg::SYM_IDLE)
         begin
            sender_cnt = sender_cnt + 1'b1;
         end
         if (tx_sym[i] == ether_pkg::SYM_JAM)
         begin
            any_jam = 1'b1;
         end
      end
   end

   // noise counts as a foreign sender, but raises no carrier
   assign collide = any_jam || line_noise || (sender_cnt > (ether_pkg::STATION_W + 1)'(1));

   // lone sender without jam is always data
   assign merged_sym = collide ? ether_pkg::SYM_JAM :
                       (sender_cnt != '0) ? ether_pkg::SYM_DATA : ether_pkg::SYM_IDLE;

   // one cycle through the wire
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         line_sym      <= ether_pkg::SYM_IDLE;
         carrier_sense <= 1'b0;
         collision     <= 1'b0;
      end
      else
      begin
         line_sym      <= merged_sym;
         carrier_sense <= sender_cnt != '0;
         collision     <= collide;
      end
   end

endmodule

`default_nettype wire

/* design/ether_bus.sv */
`timescale 1ns/1ps
`default_nettype none

module ether_bus (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic [ether_pkg::N_STATIONS-1:0] tx_req,
   input  logic                             line_noise,
   output logic [ether_pkg::N_STATIONS-1:0] tx_done,
   output ether_pkg::tx_status_t            tx_status [ether_pkg::N_STATIONS],
   output logic [ether_pkg::N_STATIONS-1:0] rx_frame
);

   // request held per station until its result
   logic [ether_pkg::N_STATIONS-1:0] tx_pending;
   // per-station drive onto the wire
   ether_pkg::sym_t                  tx_sym [ether_pkg::N_STATIONS];
   // channel outputs, fanned out to every station
   ether_pkg::sym_t                  line_sym;
   logic                             carrier_sense;
   logic                             collision;

   request_dispatch dispatch_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .tx_req     (tx_req),
      .tx_done    (tx_done),
      .tx_pending (tx_pending)
   );

   // identical stations, index only changes backoff
   for (genvar i = 0; i < ether_pkg::N_STATIONS; i++)
   begin : gen_station
      station #(
         .STATION_ID (i)
      ) station_inst (
         .clk           (clk),
         .rst_n         (rst_n),
         .tx_pending    (tx_pending[i]),
         .carrier_sense (carrier_sense),
         .collision     (collision),
         .line_sym      (line_sym),
         .tx_sym        (tx_sym[i]),
         .tx_done       (tx_done[i]),
         .tx_status     (tx_status[i]),
         .rx_frame      (rx_frame[i])
      );
   end

   bus_channel channel_inst (
      .clk           (clk),
      .rst_n         (rst_n),
      .tx_sym        (tx_sym),
      .line_noise    (line_noise),
      .line_sym      (line_sym),
      .carrier_sense (carrier_sense),
      .collision     (collision)
   );

endmodule

`default_nettype wire

/* verification/ether_bus_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module ether_bus_chk (
   input logic                             clk,
   input logic                             rst_n,
   input logic [ether_pkg::N_STATIONS-1:0] tx_done,
   input ether_pkg::tx_status_t            tx_status [ether_pkg::N_STATIONS],
   input logic                             line_noise,
   input logic                             collision
);

   for (genvar i = 0; i < ether_pkg::N_STATIONS; i++)
   begin : gen_station_chk
      // result strobe is one cycle wide
      done_single: assert property (@(posedge clk) disable iff (!rst_n)
         tx_done[i] |=> !tx_done[i])
      else $error("tx_done[%0d] high in two consecutive cycles", i);

      // a result always carries a status
      done_has_status: assert property (@(posedge clk) disable iff (!rst_n)
         tx_done[i] |-> tx_status[i] != ether_pkg::TX_NONE)
      else $error("tx_status[%0d] is TX_NONE during tx_done", i);
   end

   // channel register delays noise by one cycle
   noise_collides: assert property (@(posedge clk) disable iff (!rst_n)
      $past(line_noise) |-> collision)
   else $error("collision low one cycle after line_noise");

endmodule

bind ether_bus ether_bus_chk chk_inst (
   .clk        (clk),
   .rst_n      (rst_n),
   .tx_done    (tx_done),
   .tx_status  (tx_status),
   .line_noise (line_noise),
   .collision  (collision)
);

`default_nettype wire

/* verification/tb_ether_bus.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ether_bus;

   logic                             clk;
   logic                             rst_n;
   logic [ether_pkg::N_STATIONS-1:0] tx_req;
   logic                             line_noise;
   logic [ether_pkg::N_STATIONS-1:0] tx_done;
   ether_pkg::tx_status_t            tx_status [ether_pkg::N_STATIONS];
   logic [ether_pkg::N_STATIONS-1:0] rx_frame;

   // expected result per station, set before each request
   ether_pkg::tx_status_t exp_status [ether_pkg::N_STATIONS];
   int                    done_cnt [ether_pkg::N_STATIONS];
   int                    rx_cnt [ether_pkg::N_STATIONS];
   int                    rx_base [ether_pkg::N_STATIONS];
   // frames heard by all stations together
   int                    rx_total;
   int                    rx_total_base;
   int                    rx_total_at_done [ether_pkg::N_STATIONS];
   // stations in the order their results came back
   int                    done_order [$];
   int                    error_cnt;
   int                    test_cnt;
   int                    failed_tests;
   logic [7:0]            lfsr;

   ether_bus ether_bus_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .tx_req     (tx_req),
      .line_noise (line_noise),
      .tx_done    (tx_done),
      .tx_status  (tx_status),
      .rx_frame   (rx_frame)
   );

   // 20 ns period
   always
   begin
      #10 clk = ~clk;
   end

   // outputs are registered, so mid-cycle sampling is stable
   always @(negedge clk)
   begin
      if (rst_n)
      begin
         for (int i = 0; i < ether_pkg::N_STATIONS; i++)
         begin
            if (rx_frame[i])
            begin
               rx_cnt[i]++;
               rx_total++;
            end
         end
         for (int i = 0; i < ether_pkg::N_STATIONS; i++)
         begin
            if (tx_done[i])
            begin
               if (tx_status[i] != exp_status[i])
               begin
                  $display("Error at %0t: tx_status[%0d] expected %s, got %s", $time, i,
                           exp_status[i].name(), tx_status[i].name());
                  error_cnt++;
               end
               done_cnt[i]++;
               rx_total_at_done[i] = rx_total;
               done_order.push_back(i);
            end
         end
      end
   end

   // 8-bit Galois form, taps 0xb8
   function automatic logic [7:0] lfsr_next(input logic [7:0] s);
      if (s[0])
      begin
         return (s >> 1) ^ 8'hb8;
      end
      return s >> 1;
   endfunction

   // one step per bit taken
   task automatic lfsr_bits(input int n, output int value);
      value = 0;
      for (int b = 0; b < n; b++)
      begin
         value = (value << 1) | int'(lfsr[0]);
         lfsr = lfsr_next(lfsr);
      end
   endtask

   // noise jams every attempt, anything else ends clean after retries
   function automatic ether_pkg::tx_status_t ref_status(input logic noisy);
      return noisy ? ether_pkg::TX_FAIL : ether_pkg::TX_OK;
   endfunction

   // each good frame is heard once by every station, sender too
   function automatic int ref_rx(input logic noisy, input int senders);
      return noisy ? 0 : senders;
   endfunction

   function automatic logic [ether_pkg::N_STATIONS-1:0] one_hot(input int s);
      return (ether_pkg::N_STATIONS)'(1) << s;
   endfunction

   task automatic idle(input int n);
      repeat (n) @(posedge clk);
   endtask

   // one-cycle strobe, driven just after the edge
   task automatic pulse_request(input logic [ether_pkg::N_STATIONS-1:0] mask);
      @(posedge clk);
      #2;
      tx_req = mask;
      @(posedge clk);
      #2;
      tx_req = '0;
   endtask

   task automatic wait_done(input int s, input int target, input int limit);
      int cycles;
      cycles = 0;
      while (done_cnt[s] < target && cycles < limit)
      begin
         @(posedge clk);
         cycles++;
      end
      if (done_cnt[s] < target)
      begin
         $display("station %0d reported no result within %0d cycles", s, limit);
         error_cnt++;
      end
   endtask

   task automatic snap_rx();
      for (int i = 0; i < ether_pkg::N_STATIONS; i++)
      begin
         rx_base[i] = rx_cnt[i];
      end
      rx_total_base = rx_total;
      done_order.delete();
   endtask

   // frames seen per station since the last snapshot
   task automatic check_rx(input int expected);
      for (int i = 0; i < ether_pkg::N_STATIONS; i++)
      begin
         if (rx_cnt[i] - rx_base[i] != expected)
         begin
            $display("Error at %0t: rx_frame[%0d] count expected %0d, got %0d", $time, i,
                     expected, rx_cnt[i] - rx_base[i]);
            error_cnt++;
         end
      end
   endtask

   task automatic end_test(input string name, input int errors_before);
      test_cnt++;
      if (error_cnt == errors_before)
      begin
         $display("test %0d %s: ok", test_cnt, name);
      end
      else
      begin
         failed_tests++;
         $display("test %0d %s: failed", test_cnt, name);
      end
   endtask

   initial
   begin
      int errs;
      int s;
      int gap;
      int good;
      int target;
      clk          = 1'b0;
      rst_n        = 1'b0;
      tx_req       = '0;
      line_noise   = 1'b0;
      lfsr         = 8'd56;
      error_cnt    = 0;
      test_cnt     = 0;
      failed_tests = 0;
      rx_total     = 0;
      for (int i = 0; i < ether_pkg::N_STATIONS; i++)
      begin
         exp_status[i]       = ether_pkg::TX_NONE;
         done_cnt[i]         = 0;
         rx_cnt[i]           = 0;
         rx_total_at_done[i] = 0;
      end
      repeat (16) @(posedge clk);
      #2;
      rst_n = 1'b1;
      idle(4);

      // lone sender
      errs = error_cnt;
      snap_rx();
      exp_status[1] = ref_status(1'b0);
      target = done_cnt[1] + 1;
      pulse_request(one_hot(1));
      wait_done(1, target, 200);
      check_rx(ref_rx(1'b0, 1));
      end_test("single send", errs);
      idle(6);

      // same-cycle start, backoff separates the retries
      errs = error_cnt;
      snap_rx();
      exp_status[1] = ref_status(1'b0);
      exp_status[3] = ref_status(1'b0);
      pulse_request(one_hot(1) | one_hot(3));
      wait_done(1, done_cnt[1] + 1, 300);
      wait_done(3, done_cnt[3] + 1, 300);
      check_rx(ref_rx(1'b0, 2));
      end_test("collision and retry", errs);
      idle(6);

      // foreign transmitter on the wire for the whole request
      errs = error_cnt;
      snap_rx();
      @(posedge clk);
      #2;
      line_noise = 1'b1;
      exp_status[2] = ref_status(1'b1);
      target = done_cnt[2] + 1;
      pulse_request(one_hot(2));
      wait_done(2, target, 600);
      #2;
      line_noise = 1'b0;
      idle(8);
      check_rx(ref_rx(1'b1, 1));
      end_test("noise gives up", errs);
      idle(6);

      // second request lands while the first frame is on the line
      errs = error_cnt;
      snap_rx();
      exp_status[2] = ref_status(1'b0);
      exp_status[0] = ref_status(1'b0);
      pulse_request(one_hot(2));
      idle(1);
      pulse_request(one_hot(0));
      wait_done(2, done_cnt[2] + 1, 300);
      wait_done(0, done_cnt[0] + 1, 300);
      if (done_order.size() != 2 || done_order[0] != 2 || done_order[1] != 0)
      begin
         $display("deferred send finished out of request order");
         error_cnt++;
      end
      else if (rx_total_at_done[2] - rx_total_base != ether_pkg::N_STATIONS ||
               rx_total_at_done[0] - rx_total_base != 2 * ether_pkg::N_STATIONS)
      begin
         $display("frames were not received in request order");
         error_cnt++;
      end
      check_rx(ref_rx(1'b0, 2));
      end_test("deferral", errs);
      idle(6);

      // random stations with quiet gaps
      errs = error_cnt;
      snap_rx();
      good = 0;
      for (int n = 0; n < 6; n++)
      begin
         lfsr_bits(ether_pkg::STATION_W, s);
         lfsr_bits(4, gap);
         exp_status[s] = ref_status(1'b0);
         target = done_cnt[s] + 1;
         pulse_request(one_hot(s));
         wait_done(s, target, 200);
         good++;
         idle(gap + 4);
      end
      check_rx(ref_rx(1'b0, good));
      end_test("random singles", errs);

      $display("tests run %0d, tests failed %0d, errors %0d", test_cnt, failed_tests,
               error_cnt);
      if (error_cnt == 0)
      begin
         $display("TEST RESULT: PASS");
      end
      else
      begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* all.f */
common/ether_pkg.sv
design/request_dispatch.sv
station/frame_transmitter.sv
station/frame_receiver.sv
station/station.sv
design/bus_channel.sv
design/ether_bus.sv
verification/ether_bus_chk.sv
verification/tb_ether_bus.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_ether_bus
FILELIST := all.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))
PASS_MSG := TEST RESULT: PASS

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
